// ==== avr_exec_params.svh ====
/* widths, ALU operation codes and SREG bit positions of the execute core.
   included by the package and by every module that decodes or computes. */
`ifndef AVR_EXEC_PARAMS_SVH
`define AVR_EXEC_PARAMS_SVH

`define DATA_WIDTH      8
`define REG_ADDR_WIDTH  5
`define OPSEL_COUNT     4

`define OPSEL_ADD   4'd0
`define OPSEL_ADC   4'd1
`define OPSEL_SUB   4'd2
`define OPSEL_SBC   4'd3
`define OPSEL_AND   4'd4
`define OPSEL_EOR   4'd5
`define OPSEL_OR    4'd6
`define OPSEL_NEG   4'd7
`define OPSEL_LDI   4'd8
`define OPSEL_BSET  4'd9
`define OPSEL_BCLR  4'd10

// positions follow the AVR SREG layout.
`define FLAGS_C  0
`define FLAGS_Z  1
`define FLAGS_N  2
`define FLAGS_V  3
`define FLAGS_S  4
`define FLAGS_H  5
`define FLAGS_T  6
`define FLAGS_I  7

`endif

// ==== avr_exec_pkg.sv ====
/* shared types of the execute core, imported by the RTL and the testbench. */
`include "avr_exec_params.svh"

package avr_exec_pkg;

    // one operand or result byte.
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // status register, bit order given by the FLAGS_* macros.
    typedef logic [`DATA_WIDTH-1:0] sreg_t;

    // index into the 32-entry register file.
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // internal operation code, one of the OPSEL_* values.
    typedef logic [`OPSEL_COUNT-1:0] opsel_t;

    // raw 16-bit AVR instruction word.
    typedef logic [15:0] instr_t;

endpackage

// ==== instr_decoder.sv ====
/* input side of the core: decodes one AVR instruction word per strobe into
   registered operation, register addresses, immediate and bit select. */
`timescale 1ns/1ps
`include "avr_exec_params.svh"

module instr_decoder
    import avr_exec_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      instr_valid,
    input  instr_t    instr,
    output logic      op_valid,
    output opsel_t    opsel,
    output reg_addr_t rd_addr,
    output reg_addr_t rr_addr,
    output data_t     imm,
    output logic [2:0] bit_sel,
    output logic      illegal
);

    logic      dec_known;
    opsel_t    dec_opsel;
    reg_addr_t dec_rd;

    always_comb
    begin
        dec_known = 1'b1;
        dec_opsel = `OPSEL_ADD;
        dec_rd    = instr[8:4];
        casez (instr)
            16'b0000_11??_????_????: dec_opsel = `OPSEL_ADD;
            16'b0001_11??_????_????: dec_opsel = `OPSEL_ADC;
            16'b0001_10??_????_????: dec_opsel = `OPSEL_SUB;
            16'b0000_10??_????_????: dec_opsel = `OPSEL_SBC;
            16'b0010_00??_????_????: dec_opsel = `OPSEL_AND;
            16'b0010_01??_????_????: dec_opsel = `OPSEL_EOR;
            16'b0010_10??_????_????: dec_opsel = `OPSEL_OR;
            16'b1001_010?_????_0001: dec_opsel = `OPSEL_NEG;
            16'b1110_????_????_????:
            begin
                dec_opsel = `OPSEL_LDI;
                dec_rd    = {1'b1, instr[7:4]}; // LDI only reaches r16 to r31.
            end
            16'b1001_0100_0???_1000: dec_opsel = `OPSEL_BSET;
            16'b1001_0100_1???_1000: dec_opsel = `OPSEL_BCLR;
            default:                 dec_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            op_valid <= 1'b0;
            illegal  <= 1'b0;
            opsel    <= `OPSEL_ADD;
        end
        else
        begin
            op_valid <= instr_valid && dec_known;
            illegal  <= instr_valid && !dec_known;
            if (instr_valid)
                opsel <= dec_opsel;
        end
    end

    // operand fields only matter while op_valid is high.
    always_ff @(posedge clk)
    begin
        if (instr_valid)
        begin
            rd_addr <= dec_rd;
            rr_addr <= {instr[9], instr[3:0]};
            imm     <= {instr[11:8], instr[3:0]};
            bit_sel <= instr[6:4];
        end
    end

    a_instr_known: assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid |-> !$isunknown(instr));

endmodule

// ==== reg_file.sv ====
/* 32 x 8-bit general purpose register file with two asynchronous read
   ports for the operands and one clocked write port from writeback. */
`timescale 1ns/1ps
`include "avr_exec_params.svh"

module reg_file
    import avr_exec_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rd_addr,
    input  reg_addr_t rr_addr,
    output data_t     rd_data,
    output data_t     rr_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  data_t     wr_data
);

    data_t regs [0:(1 << `REG_ADDR_WIDTH)-1];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < (1 << `REG_ADDR_WIDTH); i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // a write at this edge is seen by the instruction read in the next cycle.
    assign rd_data = regs[rd_addr];
    assign rr_data = regs[rr_addr];

    a_wr_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> !$isunknown(wr_addr));

endmodule

// ==== alu.sv ====
/* combinational ALU: computes the result byte and the updated status flags
   for one operation from the two operands and the current SREG. */
`timescale 1ns/1ps
`include "avr_exec_params.svh"

module alu
    import avr_exec_pkg::*;
(
    input  opsel_t opsel,
    input  data_t  rd,
    input  data_t  rr,
    input  sreg_t  flags_in,
    output data_t  out,
    output sreg_t  flags_out
);

    logic                  cy_in;
    logic [`DATA_WIDTH:0]  add_full;
    logic [4:0]            add_half;
    logic [`DATA_WIDTH:0]  sub_full;
    logic [4:0]            sub_half;
    logic                  upd_zns;

    // only ADC and SBC chain the previous carry.
    assign cy_in = flags_in[`FLAGS_C] && (opsel == `OPSEL_ADC || opsel == `OPSEL_SBC);

    assign add_full = {1'b0, rd} + {1'b0, rr} + {{`DATA_WIDTH{1'b0}}, cy_in};
    assign add_half = {1'b0, rd[3:0]} + {1'b0, rr[3:0]} + {4'd0, cy_in};
    assign sub_full = {1'b0, rd} - {1'b0, rr} - {{`DATA_WIDTH{1'b0}}, cy_in};
    assign sub_half = {1'b0, rd[3:0]} - {1'b0, rr[3:0]} - {4'd0, cy_in}; // bit 4 is the borrow.

    always_comb
    begin
        out       = '0;
        flags_out = flags_in; // T and I always pass, others unless changed below.
        upd_zns   = 1'b1;
        case (opsel)
            `OPSEL_ADD,
            `OPSEL_ADC:
            begin
                out                 = add_full[`DATA_WIDTH-1:0];
                flags_out[`FLAGS_C] = add_full[`DATA_WIDTH];
                flags_out[`FLAGS_H] = add_half[4];
                flags_out[`FLAGS_V] = (rd[`DATA_WIDTH-1] == rr[`DATA_WIDTH-1]) &&
                                      (out[`DATA_WIDTH-1] != rd[`DATA_WIDTH-1]);
            end
            `OPSEL_SUB,
            `OPSEL_SBC:
            begin
                out                 = sub_full[`DATA_WIDTH-1:0];
                flags_out[`FLAGS_C] = sub_full[`DATA_WIDTH];
                flags_out[`FLAGS_H] = sub_half[4];
                flags_out[`FLAGS_V] = (rd[`DATA_WIDTH-1] != rr[`DATA_WIDTH-1]) &&
                                      (out[`DATA_WIDTH-1] != rd[`DATA_WIDTH-1]);
            end
            `OPSEL_AND:
            begin
                out                 = rd & rr;
                flags_out[`FLAGS_V] = 1'b0;
            end
            `OPSEL_EOR:
            begin
                out                 = rd ^ rr;
                flags_out[`FLAGS_V] = 1'b0;
            end
            `OPSEL_OR:
            begin
                out                 = rd | rr;
                flags_out[`FLAGS_V] = 1'b0;
            end
            `OPSEL_NEG:
            begin
                // C and H are kept here, unlike a real AVR NEG.
                out                 = '0 - rd;
                flags_out[`FLAGS_V] = 1'b0;
            end
            `OPSEL_LDI:
            begin
                out     = rr; // the top level routes the immediate onto rr.
                upd_zns = 1'b0;
            end
            default:
            begin
                upd_zns = 1'b0;
            end
        endcase

        if (upd_zns)
        begin
            flags_out[`FLAGS_Z] = (out == '0);
            flags_out[`FLAGS_N] = out[`DATA_WIDTH-1];
            flags_out[`FLAGS_S] = flags_out[`FLAGS_N] ^ flags_out[`FLAGS_V];
        end
    end

endmodule

// ==== status_reg.sv ====
/* SREG of the core. takes the ALU flags for every executed operation and
   sets or clears a single bit for BSET and BCLR. */
`timescale 1ns/1ps
`include "avr_exec_params.svh"

module status_reg
    import avr_exec_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       op_valid,
    input  opsel_t     opsel,
    input  logic [2:0] bit_sel,
    input  sreg_t      flags_in,
    output sreg_t      sreg
);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sreg <= '0;
        end
        else if (op_valid)
        begin
            case (opsel)
                `OPSEL_BSET: sreg[bit_sel] <= 1'b1;
                `OPSEL_BCLR: sreg[bit_sel] <= 1'b0;
                default:     sreg <= flags_in; // LDI gets its own flags back.
            endcase
        end
    end

endmodule

// ==== writeback_stage.sv ====
/* output side of the core: registers the ALU result of every writing
   instruction and drives both the register-file write and the result port. */
`timescale 1ns/1ps
`include "avr_exec_params.svh"

module writeback_stage
    import avr_exec_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      op_valid,
    input  opsel_t    opsel,
    input  data_t     alu_out,
    input  reg_addr_t rd_addr,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output data_t     wr_data,
    output logic      result_valid,
    output data_t     result,
    output reg_addr_t result_addr
);

    // BSET and BCLR touch only the SREG.
    assign wr_en   = op_valid && (opsel != `OPSEL_BSET) && (opsel != `OPSEL_BCLR);

    // the register file takes the result at the same edge as the SREG.
    assign wr_addr = rd_addr;
    assign wr_data = alu_out;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            result_valid <= 1'b0;
        else
            result_valid <= wr_en;
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            result_addr <= rd_addr;
            result      <= alu_out;  // the reported result is the one written.
        end
    end

    a_result_known: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid |-> !$isunknown({result, result_addr}));

endmodule

// ==== avr_exec_top.sv ====
/* execute core top: decoder, register file, ALU, SREG and writeback.
   one instruction per instr_valid strobe, result two cycles later. */
`timescale 1ns/1ps
`include "avr_exec_params.svh"

module avr_exec_top
    import avr_exec_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      instr_valid,
    input  instr_t    instr,
    output logic      result_valid,
    output data_t     result,
    output reg_addr_t result_addr,
    output sreg_t     sreg,
    output logic      illegal
);

    logic       op_valid;
    opsel_t     opsel;
    reg_addr_t  rd_addr;
    reg_addr_t  rr_addr;
    data_t      imm;
    logic [2:0] bit_sel;
    data_t      rd_data;
    data_t      rr_data;
    data_t      rr_operand;
    data_t      alu_out;
    sreg_t      flags_out;
    logic       wr_en;
    reg_addr_t  wr_addr;
    data_t      wr_data;

    instr_decoder u_instr_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .op_valid    (op_valid),
        .opsel       (opsel),
        .rd_addr     (rd_addr),
        .rr_addr     (rr_addr),
        .imm         (imm),
        .bit_sel     (bit_sel),
        .illegal     (illegal)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_addr (rd_addr),
        .rr_addr (rr_addr),
        .rd_data (rd_data),
        .rr_data (rr_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    // LDI takes its second operand from the instruction word.
    assign rr_operand = (opsel == `OPSEL_LDI) ? imm : rr_data;

    alu u_alu (
        .opsel     (opsel),
        .rd        (rd_data),
        .rr        (rr_operand),
        .flags_in  (sreg),
        .out       (alu_out),
        .flags_out (flags_out)
    );

    status_reg u_status_reg (
        .clk      (clk),
        .arst_n   (arst_n),
        .op_valid (op_valid),
        .opsel    (opsel),
        .bit_sel  (bit_sel),
        .flags_in (flags_out),
        .sreg     (sreg)
    );

    writeback_stage u_writeback_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .op_valid     (op_valid),
        .opsel        (opsel),
        .alu_out      (alu_out),
        .rd_addr      (rd_addr),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .result_valid (result_valid),
        .result       (result),
        .result_addr  (result_addr)
    );

endmodule

// ==== tb_avr_exec.sv ====
/* testbench for the execute core. runs a table of instructions through the
   DUT, checks results and SREG against a reference model, then a LDI burst. */
`timescale 1ns/1ps
`include "avr_exec_params.svh"

module tb_avr_exec
    import avr_exec_pkg::*;
();

    localparam opsel_t OP_BAD = 4'hF; // raw word, no decodable opcode.

    logic      clk;
    logic      arst_n;
    logic      instr_valid;
    instr_t    instr;
    logic      result_valid;
    data_t     result;
    reg_addr_t result_addr;
    sreg_t     sreg;
    logic      illegal;

    opsel_t op_q[$];
    int     d_q[$];
    int     r_q[$];
    int     k_q[$];
    instr_t raw_q[$];
    bit     has_want_q[$];
    data_t  want_res_q[$];
    sreg_t  want_on_q[$];

    data_t model_regs [0:31];
    sreg_t model_sreg;
    int    mismatch_count;
    int    other_count;
    data_t burst_val [0:15];

    avr_exec_top u_avr_exec_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result),
        .result_addr  (result_addr),
        .sreg         (sreg),
        .illegal      (illegal)
    );

    always #50 clk = ~clk;

    function automatic instr_t encode(opsel_t op, int d, int r, int k, instr_t raw);
        reg_addr_t dd;
        reg_addr_t rr;
        data_t     kk;
        dd = d;
        rr = r;
        kk = k;
        case (op)
            `OPSEL_ADD:  return {6'b000011, rr[4], dd, rr[3:0]};
            `OPSEL_ADC:  return {6'b000111, rr[4], dd, rr[3:0]};
            `OPSEL_SUB:  return {6'b000110, rr[4], dd, rr[3:0]};
            `OPSEL_SBC:  return {6'b000010, rr[4], dd, rr[3:0]};
            `OPSEL_AND:  return {6'b001000, rr[4], dd, rr[3:0]};
            `OPSEL_EOR:  return {6'b001001, rr[4], dd, rr[3:0]};
            `OPSEL_OR:   return {6'b001010, rr[4], dd, rr[3:0]};
            `OPSEL_NEG:  return {7'b1001010, dd, 4'b0001};
            `OPSEL_LDI:  return {4'b1110, kk[7:4], dd[3:0], kk[3:0]};
            `OPSEL_BSET: return {9'b100101000, kk[2:0], 4'b1000};
            `OPSEL_BCLR: return {9'b100101001, kk[2:0], 4'b1000};
            default:     return raw;
        endcase
    endfunction

    // flag equations written from the AVR instruction set rules.
    task automatic model_alu(input opsel_t op, input data_t a, input data_t b,
                             input sreg_t s, output data_t r, output sreg_t f);
        logic cin;
        cin = s[`FLAGS_C] && (op == `OPSEL_ADC || op == `OPSEL_SBC);
        f = s;
        r = b;
        case (op)
            `OPSEL_ADD, `OPSEL_ADC:
            begin
                r = a + b + cin;
                f[`FLAGS_C] = (a[7] & b[7]) | (b[7] & ~r[7]) | (~r[7] & a[7]);
                f[`FLAGS_H] = (a[3] & b[3]) | (b[3] & ~r[3]) | (~r[3] & a[3]);
                f[`FLAGS_V] = (a[7] & b[7] & ~r[7]) | (~a[7] & ~b[7] & r[7]);
            end
            `OPSEL_SUB, `OPSEL_SBC:
            begin
                r = a - b - cin;
                f[`FLAGS_C] = (~a[7] & b[7]) | (b[7] & r[7]) | (r[7] & ~a[7]);
                f[`FLAGS_H] = (~a[3] & b[3]) | (b[3] & r[3]) | (r[3] & ~a[3]);
                f[`FLAGS_V] = (a[7] & ~b[7] & ~r[7]) | (~a[7] & b[7] & r[7]);
            end
            `OPSEL_AND: r = a & b;
            `OPSEL_EOR: r = a ^ b;
            `OPSEL_OR:  r = a | b;
            `OPSEL_NEG: r = 8'd0 - a;
            default:    r = b;
        endcase
        if (op inside {`OPSEL_AND, `OPSEL_EOR, `OPSEL_OR, `OPSEL_NEG})
            f[`FLAGS_V] = 1'b0;
        if (op inside {`OPSEL_ADD, `OPSEL_ADC, `OPSEL_SUB, `OPSEL_SBC,
                       `OPSEL_AND, `OPSEL_EOR, `OPSEL_OR, `OPSEL_NEG})
        begin
            f[`FLAGS_Z] = (r == 8'd0);
            f[`FLAGS_N] = r[7];
            f[`FLAGS_S] = r[7] ^ f[`FLAGS_V];
        end
    endtask

    task automatic add_entry(opsel_t op, int d, int r, int k);
        op_q.push_back(op);
        d_q.push_back(d);
        r_q.push_back(r);
        k_q.push_back(k);
        raw_q.push_back(16'h0000);
        has_want_q.push_back(1'b0);
        want_res_q.push_back(8'h00);
        want_on_q.push_back(8'h00);
    endtask

    // fixed expectation for the entry added last.
    task automatic add_want(data_t res, sreg_t on);
        int last;
        last = has_want_q.size() - 1;
        has_want_q[last] = 1'b1;
        want_res_q[last] = res;
        want_on_q[last]  = on;
    endtask

    task automatic check_result(data_t exp, reg_addr_t addr);
        if (result !== exp || result_addr !== addr)
        begin
            $display("Mismatch at %0t: result r%0d=%02h, expected r%0d=%02h",
                     $time, result_addr, result, addr, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_sreg(sreg_t exp);
        if (sreg !== exp)
        begin
            $display("Mismatch at %0t: sreg %08b, expected %08b", $time, sreg, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_illegal(logic exp);
        if (illegal !== exp)
        begin
            $display("Mismatch at %0t: illegal %0b, expected %0b", $time, illegal, exp);
            mismatch_count++;
        end
    endtask

    task automatic run_entry(int i);
        data_t     a;
        data_t     b;
        data_t     exp_res;
        sreg_t     exp_sreg;
        reg_addr_t dest;
        int        waited;
        a = model_regs[d_q[i]];
        b = (op_q[i] == `OPSEL_LDI) ? data_t'(k_q[i]) : model_regs[r_q[i]];
        dest = d_q[i];
        model_alu(op_q[i], a, b, model_sreg, exp_res, exp_sreg);
        if (op_q[i] == `OPSEL_BSET)
            exp_sreg[k_q[i]] = 1'b1;
        if (op_q[i] == `OPSEL_BCLR)
            exp_sreg[k_q[i]] = 1'b0;
        instr_valid = 1'b1;
        instr = encode(op_q[i], d_q[i], r_q[i], k_q[i], raw_q[i]);
        @(negedge clk);
        instr_valid = 1'b0;
        check_illegal(op_q[i] == OP_BAD);
        if (op_q[i] inside {`OPSEL_BSET, `OPSEL_BCLR, OP_BAD})
        begin
            @(negedge clk);
            if (result_valid !== 1'b0)
            begin
                $display("result_valid pulsed for an instruction that writes no register");
                other_count++;
            end
            check_sreg(exp_sreg);
        end
        else
        begin
            waited = 0;
            while (result_valid !== 1'b1 && waited < 10)
            begin
                @(negedge clk);
                waited++;
            end
            if (result_valid !== 1'b1)
            begin
                $display("timeout: no result_valid for table entry %0d", i);
                other_count++;
            end
            check_result(exp_res, dest);
            check_sreg(exp_sreg);
            if (has_want_q[i])
            begin
                check_result(want_res_q[i], dest);
                check_sreg(exp_sreg | want_on_q[i]);
            end
            model_regs[dest] = exp_res;
        end
        model_sreg = exp_sreg;
    endtask

    // LDI and, in the very next cycle, an ALU instruction that reads the loaded register.
    task automatic run_back_to_back(opsel_t op, int d, int r, data_t k);
        data_t exp_res;
        sreg_t exp_sreg;
        instr_valid = 1'b1;
        instr = encode(`OPSEL_LDI, d, 0, k, 16'h0000);
        @(negedge clk);
        model_regs[d] = k;
        model_alu(op, model_regs[d], model_regs[r], model_sreg, exp_res, exp_sreg);
        instr = encode(op, d, r, 0, 16'h0000);
        @(negedge clk);
        instr_valid = 1'b0;
        if (result_valid !== 1'b1)
        begin
            $display("result_valid missing for the LDI of a back-to-back pair");
            other_count++;
        end
        check_result(k, reg_addr_t'(d));
        @(negedge clk);
        if (result_valid !== 1'b1)
        begin
            $display("result_valid missing for the dependent instruction of a pair");
            other_count++;
        end
        check_result(exp_res, reg_addr_t'(d));
        check_sreg(exp_sreg);
        model_regs[d] = exp_res;
        model_sreg = exp_sreg;
    endtask

    task automatic run_ldi_burst();
        int i;
        for (i = 0; i < 18; i++)
        begin
            if (i < 16)
            begin
                burst_val[i] = data_t'($urandom);
                instr_valid = 1'b1;
                instr = encode(`OPSEL_LDI, 16 + i, 0, burst_val[i], 16'h0000);
            end
            else
            begin
                instr_valid = 1'b0;
            end
            if (i >= 2)
            begin
                if (result_valid !== 1'b1)
                begin
                    $display("result_valid missing in LDI burst at step %0d", i);
                    other_count++;
                end
                check_result(burst_val[i-2], reg_addr_t'(16 + i - 2));
                model_regs[16 + i - 2] = burst_val[i-2];
            end
            @(negedge clk);
        end
        check_sreg(model_sreg);
    endtask

    initial
    begin
        clk = 1'b0;
        arst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        mismatch_count = 0;
        other_count = 0;
        model_sreg = '0;
        for (int j = 0; j < 32; j++)
            model_regs[j] = '0;
        void'($urandom(80));

        add_entry(`OPSEL_LDI, 16, 0, 8'h7F);
        add_entry(`OPSEL_LDI, 17, 0, 8'h01);
        add_entry(`OPSEL_ADD, 16, 17, 0);
        add_want(8'h80, 8'b0010_1100);           // H, V and N.
        add_entry(`OPSEL_LDI, 18, 0, 8'hFF);
        add_entry(`OPSEL_ADD, 18, 17, 0);
        add_want(8'h00, 8'b0010_0011);           // H, Z and C.
        add_entry(`OPSEL_ADC, 17, 17, 0);
        add_want(8'h03, 8'h00);
        add_entry(`OPSEL_LDI, 17, 0, 8'h01);
        add_entry(`OPSEL_LDI, 19, 0, 8'h80);
        add_entry(`OPSEL_SUB, 19, 17, 0);
        add_want(8'h7F, 8'b0000_1000);
        add_entry(`OPSEL_LDI, 20, 0, 8'h05);
        add_entry(`OPSEL_LDI, 21, 0, 8'h09);
        add_entry(`OPSEL_SUB, 20, 21, 0);
        add_want(8'hFC, 8'b0000_0001);
        add_entry(`OPSEL_SBC, 20, 21, 0);
        add_want(8'hF2, 8'h00);
        add_entry(`OPSEL_NEG, 21, 0, 0);
        add_want(8'hF7, 8'h00);
        add_entry(`OPSEL_BSET, 0, 0, `FLAGS_T);
        add_entry(`OPSEL_BSET, 0, 0, `FLAGS_I);
        for (int j = 0; j < 3; j++)
        begin
            add_entry(`OPSEL_LDI, 22, 0, $urandom & 8'hFF);
            add_entry(`OPSEL_LDI, 23, 0, $urandom & 8'hFF);
            add_entry(opsel_t'(`OPSEL_AND + j), 22, 23, 0);
            add_entry(opsel_t'(`OPSEL_OR - j), 23, 22, 0);
        end
        add_entry(`OPSEL_BCLR, 0, 0, `FLAGS_T);
        add_entry(`OPSEL_LDI, 24, 0, 8'h5A);
        add_entry(`OPSEL_ADD, 24, 24, 0);        // dependent on the LDI just before.
        add_want(8'hB4, 8'b0000_1100);
        add_entry(OP_BAD, 0, 0, 0);
        raw_q[raw_q.size() - 1] = 16'hFFFF;
        add_entry(OP_BAD, 0, 0, 0);
        raw_q[raw_q.size() - 1] = 16'h0000;
        add_entry(`OPSEL_OR, 24, 24, 0);         // reads r24 back after the illegal words.
        add_want(8'hB4, 8'h00);
        add_entry(`OPSEL_BCLR, 0, 0, `FLAGS_I);

        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < op_q.size(); i++)
            run_entry(i);
        run_back_to_back(`OPSEL_ADD, 25, 25, data_t'($urandom));
        run_back_to_back(`OPSEL_ADC, 26, 25, data_t'($urandom));
        run_ldi_burst();
        @(negedge clk);

        $display("errors: mismatch=%0d other=%0d", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== avr_exec.f ====
+incdir+.
avr_exec_pkg.sv
instr_decoder.sv
reg_file.sv
alu.sv
status_reg.sv
writeback_stage.sv
avr_exec_top.sv
tb_avr_exec.sv

// ==== Makefile ====
# Verilator build and run of the execute core testbench.

VERILATOR ?= verilator
TOP       ?= tb_avr_exec
FILELIST  ?= avr_exec.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wall -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf $(BUILD_DIR)
